// File: hw/his_defs.svh
`ifndef HIS_DEFS_SVH
`define HIS_DEFS_SVH

// Bin address width, 64 bins
`define NB 6

// Number of histogram bins
`define BIN_NUM (1 << `NB)

// Width of one bin count, saturates at all ones
`define PEAK_MAX 16

// Events that make up one acquisition
`define HIS_EVENTS 200

`endif

// File: hw/his_pkg.sv
`include "his_defs.svh"

package his_pkg;

    // Bin index and bin count
    typedef logic [`NB-1:0] bin_addr_t;
    typedef logic [`PEAK_MAX-1:0] bin_count_t;

    // Events seen so far in the running acquisition
    typedef logic [$clog2(`HIS_EVENTS)-1:0] ev_cnt_t;

    // One sampled event on its way into the memory
    typedef struct packed {
        bin_addr_t addr;
        logic bank;  // Bank to update
        logic last;  // Completes the acquisition
    } event_t;

    // One bin leaving the readout
    typedef struct packed {
        logic his_num;  // Bank the bin came from
        bin_addr_t addr;
        bin_count_t count;
    } bin_word_t;

endpackage

// File: hw/event_sampler.sv
`timescale 1ns/10ps
`include "his_defs.svh"

module event_sampler (
    input  logic clk,
    input  logic res,
    input  logic wr_en,
    input  his_pkg::bin_addr_t addr,
    input  logic ready,
    input  logic [1:0] busy_bank,
    output logic ev_valid,
    output his_pkg::event_t ev,
    output logic his_num,
    output logic overrun
);

    his_pkg::ev_cnt_t ev_cnt;  // Accepted events in this acquisition

    logic target_busy;
    logic accept;
    logic drop;
    logic last_ev;

    // Bank being filled is still being swept out
    assign target_busy = busy_bank[his_num];

    assign accept = wr_en && ready && !target_busy;
    assign drop = wr_en && ready && target_busy;

    assign last_ev = (ev_cnt == his_pkg::ev_cnt_t'(`HIS_EVENTS - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ev_valid <= 1'b0;
            ev_cnt <= '0;
            his_num <= 1'b0;
            overrun <= 1'b0;
        end else begin
            ev_valid <= accept;

            if (accept) begin
                if (last_ev) begin
                    ev_cnt <= '0;
                    his_num <= !his_num;  // Next acquisition goes to the other bank
                end else begin
                    ev_cnt <= ev_cnt + 1'b1;
                end
            end

            if (drop) begin
                overrun <= 1'b1;  // Sticky until reset
            end
        end
    end

    // Event payload, qualified by ev_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            ev.addr <= addr;
            ev.bank <= his_num;
            ev.last <= last_ev;
        end
    end

endmodule

// File: hw/his_memory.sv
`timescale 1ns/10ps
`include "his_defs.svh"

module his_memory (
    input  logic clk,
    input  logic res,
    input  logic ev_valid,
    input  his_pkg::event_t ev,
    input  logic rd_en,
    input  logic rd_bank,
    input  his_pkg::bin_addr_t rd_addr,
    output his_pkg::bin_count_t rd_count,
    output logic ready,
    output logic bank_done,
    output logic done_bank
);

    his_pkg::bin_count_t mem [2][`BIN_NUM];  // Two histogram banks

    his_pkg::bin_addr_t clr_addr;  // Initial clear sweep

    // Increment pipeline, stage 1 holds the event and its old count
    logic s1_valid;
    his_pkg::event_t s1_ev;
    his_pkg::bin_count_t s1_count;

    his_pkg::bin_count_t wr_count;
    logic fwd_hit;

    // Readout path
    his_pkg::bin_count_t rd_hold;

    // Per bank write port
    logic [1:0] mem_we;
    his_pkg::bin_addr_t mem_wa [2];
    his_pkg::bin_count_t mem_wd [2];

    // Saturating increment
    assign wr_count = (&s1_count) ? s1_count : s1_count + 1'b1;

    // Same bin is being written this cycle, take the new value
    assign fwd_hit = ev_valid && s1_valid &&
                     (s1_ev.bank == ev.bank) && (s1_ev.addr == ev.addr);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clr_addr <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            clr_addr <= clr_addr + 1'b1;
            if (&clr_addr) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            bank_done <= 1'b0;
            done_bank <= 1'b0;
        end else begin
            s1_valid <= ev_valid;
            bank_done <= s1_valid && s1_ev.last;  // Cycle after the last write
            if (s1_valid && s1_ev.last) begin
                done_bank <= s1_ev.bank;
            end
        end
    end

    // Read stage of the increment
    always_ff @(posedge clk) begin
        if (ev_valid) begin
            s1_ev <= ev;
            if (fwd_hit) begin
                s1_count <= wr_count;
            end else begin
                s1_count <= mem[ev.bank][ev.addr];
            end
        end
    end

    // Clear sweep first, then increments, then read-and-clear
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            mem_we[b] = 1'b0;
            mem_wa[b] = clr_addr;
            mem_wd[b] = '0;
            if (!ready) begin
                mem_we[b] = 1'b1;
            end else if (s1_valid && (s1_ev.bank == 1'(b))) begin
                mem_we[b] = 1'b1;
                mem_wa[b] = s1_ev.addr;
                mem_wd[b] = wr_count;
            end else if (rd_en && (rd_bank == 1'(b))) begin
                mem_we[b] = 1'b1;
                mem_wa[b] = rd_addr;  // Clear on read
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (mem_we[b]) begin
                mem[b][mem_wa[b]] <= mem_wd[b];
            end
        end
    end

    // Count comes back two cycles after the read request
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_hold <= mem[rd_bank][rd_addr];
        end
        rd_count <= rd_hold;
    end

endmodule

// File: hw/his_readout.sv
`timescale 1ns/10ps
`include "his_defs.svh"

module his_readout (
    input  logic clk,
    input  logic res,
    input  logic bank_done,
    input  logic done_bank,
    input  his_pkg::bin_count_t rd_count,
    output logic rd_en,
    output logic rd_bank,
    output his_pkg::bin_addr_t rd_addr,
    output logic bin_valid,
    output his_pkg::bin_word_t bin_word,
    output logic data_finish,
    output logic [1:0] busy_bank
);

    typedef enum logic [1:0] {
        st_idle,
        st_sweep,
        st_drain
    } state_t;

    state_t state;

    his_pkg::bin_addr_t addr_cnt;
    logic bank_sel;
    logic last_rd;

    // Bank and address follow the read through the memory latency
    logic d1_valid;
    logic d1_bank;
    his_pkg::bin_addr_t d1_addr;
    logic d2_valid;
    logic d2_bank;
    his_pkg::bin_addr_t d2_addr;
    logic d1_last;

    assign rd_en = (state == st_sweep);
    assign rd_bank = bank_sel;
    assign rd_addr = addr_cnt;

    assign last_rd = &addr_cnt;
    assign d1_last = d1_valid && (&d1_addr);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= st_idle;
            addr_cnt <= '0;
            bank_sel <= 1'b0;
            busy_bank <= 2'b00;
            d1_valid <= 1'b0;
            d2_valid <= 1'b0;
        end else begin
            d1_valid <= rd_en;
            d2_valid <= d1_valid;

            case (state)
                st_idle: begin
                    if (bank_done) begin
                        state <= st_sweep;
                        bank_sel <= done_bank;
                        busy_bank[done_bank] <= 1'b1;
                    end
                end
                st_sweep: begin
                    addr_cnt <= addr_cnt + 1'b1;  // Wraps back to zero after the last bin
                    if (last_rd) begin
                        state <= st_drain;
                    end
                end
                st_drain: begin
                    // Last bin leaves next cycle
                    if (d1_last) begin
                        state <= st_idle;
                        busy_bank[bank_sel] <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        d1_bank <= bank_sel;
        d1_addr <= addr_cnt;
        d2_bank <= d1_bank;
        d2_addr <= d1_addr;
    end

    assign bin_valid = d2_valid;
    assign bin_word.his_num = d2_bank;
    assign bin_word.addr = d2_addr;
    assign bin_word.count = rd_count;

    assign data_finish = d2_valid && (&d2_addr);  // Final bin of the sweep

endmodule

// File: hw/his_builder.sv
`timescale 1ns/10ps

module his_builder (
    input  logic clk,
    input  logic res,
    input  logic wr_en,
    input  his_pkg::bin_addr_t addr,
    output logic bin_valid,
    output his_pkg::bin_word_t bin_word,
    output logic data_finish,
    output logic his_num,
    output logic overrun,
    output logic ready
);

    logic ev_valid;
    his_pkg::event_t ev;

    logic bank_done;
    logic done_bank;

    logic rd_en;
    logic rd_bank;
    his_pkg::bin_addr_t rd_addr;
    his_pkg::bin_count_t rd_count;

    logic [1:0] busy_bank;

    event_sampler u_sampler (
        .clk(clk),
        .res(res),
        .wr_en(wr_en),
        .addr(addr),
        .ready(ready),
        .busy_bank(busy_bank),
        .ev_valid(ev_valid),
        .ev(ev),
        .his_num(his_num),
        .overrun(overrun)
    );

    his_memory u_memory (
        .clk(clk),
        .res(res),
        .ev_valid(ev_valid),
        .ev(ev),
        .rd_en(rd_en),
        .rd_bank(rd_bank),
        .rd_addr(rd_addr),
        .rd_count(rd_count),
        .ready(ready),
        .bank_done(bank_done),
        .done_bank(done_bank)
    );

    his_readout u_readout (
        .clk(clk),
        .res(res),
        .bank_done(bank_done),
        .done_bank(done_bank),
        .rd_count(rd_count),
        .rd_en(rd_en),
        .rd_bank(rd_bank),
        .rd_addr(rd_addr),
        .bin_valid(bin_valid),
        .bin_word(bin_word),
        .data_finish(data_finish),
        .busy_bank(busy_bank)
    );

endmodule

// File: dv/his_builder_tb.sv
`timescale 1ns/10ps
`include "his_defs.svh"

module his_builder_tb;

    localparam int NROWS = 6;

    typedef enum logic [1:0] {
        k_fixed,     // Every event to one bin
        k_random,
        k_same_run,  // Runs of four events to one bin
        k_pair       // Two neighbouring bins in turn
    } kind_t;

    typedef struct packed {
        kind_t kind;
        his_pkg::bin_addr_t bin;
        logic [3:0] gap;  // Idle cycles after each event
        logic exp_ovr;
    } row_t;

    logic clk;
    logic res;
    logic wr_en;
    his_pkg::bin_addr_t addr;
    logic bin_valid;
    his_pkg::bin_word_t bin_word;
    logic data_finish;
    logic his_num;
    logic overrun;
    logic ready;

    row_t rows [NROWS];
    integer seed;
    int cyc;
    int limit;

    // Reference histogram and bank model
    his_pkg::bin_count_t ref_cnt [2][`BIN_NUM];
    logic stim_bank;
    int ev_count;
    int busy_from [2];
    int busy_to [2];
    int last_sample;

    // Expected results, oldest first
    his_pkg::bin_word_t exp_q [$];
    int toggle_q [$];
    int ovr_edge_q [$];
    logic ovr_exp_q [$];
    logic exp_his_num;
    logic exp_ovr;
    his_pkg::bin_word_t mon_word;

    his_builder dut (
        .clk(clk),
        .res(res),
        .wr_en(wr_en),
        .addr(addr),
        .bin_valid(bin_valid),
        .bin_word(bin_word),
        .data_finish(data_finish),
        .his_num(his_num),
        .overrun(overrun),
        .ready(ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            abort_run($sformatf("timeout: no end after %0d cycles", limit));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bin(input his_pkg::bin_word_t exp, input his_pkg::bin_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("error at %0t ns: bin_word expected %0d/%0d/%0d got %0d/%0d/%0d",
                $time, exp.his_num, exp.addr, exp.count, act.his_num, act.addr, act.count));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("error at %0t ns: %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic check_bank(input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("error at %0t ns: his_num expected %b got %b", $time, exp, act));
        end
    endtask

    function automatic his_pkg::bin_count_t sat_inc(input his_pkg::bin_count_t c);
        if (c == {`PEAK_MAX{1'b1}}) begin
            return c;  // Count holds at all ones
        end
        return c + 1'b1;
    endfunction

    task automatic set_row(input int idx, input kind_t kind, input his_pkg::bin_addr_t bin,
                           input logic [3:0] gap, input logic ovr);
        rows[idx].kind = kind;
        rows[idx].bin = bin;
        rows[idx].gap = gap;
        rows[idx].exp_ovr = ovr;
    endtask

    // Finished bank leaves in ascending bin order and is cleared as it goes
    task automatic push_sweep(input logic b);
        his_pkg::bin_word_t w;
        for (int i = 0; i < `BIN_NUM; i++) begin
            w.his_num = b;
            w.addr = his_pkg::bin_addr_t'(i);
            w.count = ref_cnt[b][i];
            exp_q.push_back(w);
            ref_cnt[b][i] = '0;
        end
    endtask

    task automatic drive_event(input his_pkg::bin_addr_t a);
        int s;
        @(posedge clk);
        wr_en <= 1'b1;
        addr <= a;
        s = cyc + 2;  // Edge that samples this event
        last_sample = s;
        if (s >= busy_from[stim_bank] && s <= busy_to[stim_bank]) begin
            return;  // Bank still being read out, event is lost
        end
        ref_cnt[stim_bank][a] = sat_inc(ref_cnt[stim_bank][a]);
        ev_count++;
        if (ev_count == `HIS_EVENTS) begin
            ev_count = 0;
            push_sweep(stim_bank);
            toggle_q.push_back(s);
            busy_from[stim_bank] = s + 4;
            busy_to[stim_bank] = s + `BIN_NUM + 4;
            stim_bank = !stim_bank;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // Output monitor, sampled away from the driving edge
    always @(negedge clk) begin
        if (res) begin
            while (toggle_q.size() > 0 && toggle_q[0] <= cyc) begin
                void'(toggle_q.pop_front());
                exp_his_num = !exp_his_num;
            end
            check_bank(exp_his_num, his_num);
            if (ovr_edge_q.size() > 0 && ovr_edge_q[0] <= cyc) begin
                void'(ovr_edge_q.pop_front());
                exp_ovr = ovr_exp_q.pop_front();
                check_flag("overrun", exp_ovr, overrun);
            end
            if (bin_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("a bin word came out with no finished acquisition pending");
                end else begin
                    mon_word = exp_q.pop_front();
                    check_bin(mon_word, bin_word);
                    check_flag("data_finish",
                        mon_word.addr == his_pkg::bin_addr_t'(`BIN_NUM - 1), data_finish);
                end
            end else begin
                check_flag("data_finish", 1'b0, data_finish);
            end
        end
    end

    initial begin
        int n;
        int max_gap;
        his_pkg::bin_addr_t a;
        clk = 1'b0;
        res = 1'b0;
        wr_en = 1'b0;
        addr = '0;
        seed = 20804;
        cyc = 0;
        limit = 0;
        stim_bank = 1'b0;
        exp_his_num = 1'b0;
        ev_count = 0;
        for (int b = 0; b < 2; b++) begin
            busy_from[b] = 1;
            busy_to[b] = 0;
            for (int i = 0; i < `BIN_NUM; i++) begin
                ref_cnt[b][i] = '0;
            end
        end

        set_row(0, k_fixed, 6'd5, 4'd0, 1'b0);     // All 200 into bin 5
        set_row(1, k_random, 6'd0, 4'd1, 1'b0);
        set_row(2, k_same_run, 6'd10, 4'd0, 1'b0); // Bank 0 again after its readout
        set_row(3, k_pair, 6'd62, 4'd0, 1'b0);
        set_row(4, k_fixed, 6'd63, 4'd0, 1'b0);    // No gap, other bank takes these
        set_row(5, k_random, 6'd0, 4'd3, 1'b0);

        max_gap = 0;
        for (int r = 0; r < NROWS; r++) begin
            if (rows[r].gap > max_gap) max_gap = rows[r].gap;
        end
        limit = NROWS * (`HIS_EVENTS * (max_gap + 1) + `BIN_NUM + 50);

        repeat (10) @(posedge clk);
        res <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!ready) begin
            n++;  // Cycles spent in the clear sweep
            @(negedge clk);
        end
        if (n != `BIN_NUM) begin
            abort_run($sformatf("ready rose after %0d cycles instead of %0d", n, `BIN_NUM));
        end

        for (int r = 0; r < NROWS; r++) begin
            for (int i = 0; i < `HIS_EVENTS; i++) begin
                case (rows[r].kind)
                    k_fixed: a = rows[r].bin;
                    k_random: a = his_pkg::bin_addr_t'($random(seed));
                    k_same_run: a = rows[r].bin + his_pkg::bin_addr_t'(i / 4);
                    default: a = (i % 2 == 0) ? rows[r].bin : rows[r].bin + 1'b1;
                endcase
                drive_event(a);
                repeat (rows[r].gap) idle_cycle();
            end
            ovr_edge_q.push_back(last_sample);
            ovr_exp_q.push_back(rows[r].exp_ovr);
        end
        idle_cycle();

        // Let the last readout drain
        while (exp_q.size() > 0 || toggle_q.size() > 0 || ovr_edge_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (4) @(negedge clk);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: files.f
+incdir+hw
hw/his_pkg.sv
hw/event_sampler.sv
hw/his_memory.sv
hw/his_readout.sv
hw/his_builder.sv
dv/his_builder_tb.sv
